// File: hw/pad_pkg.sv
// Pad word layout is fixed by the pad hardware and only covers the eight standard buttons
`default_nettype none

package pad_pkg;

	// ----------------------------------------------------------------------
	// Button fields in shift order
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic a;		// First bit out after latch, lands in the MSB
		logic b;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;	// Last bit out, lands in the LSB
	} pad_buttons_t;

	// One pad byte, seen as wire bits or as named buttons
	typedef union packed {
		logic [7:0]   raw;		// Bit order as shifted in
		pad_buttons_t buttons;	// Same byte by name
	} pad_word_u;

	// ----------------------------------------------------------------------
	// Per-poll report of one pad
	// ----------------------------------------------------------------------
	typedef struct packed {
		pad_buttons_t held;		// Down in this poll
		pad_buttons_t pressed;	// Down now and up in the poll before
		pad_buttons_t released;	// Up now and down in the poll before
	} pad_report_t;

endpackage

`default_nettype wire

// File: hw/link_pkg.sv
// Link states are sized for a 3-bit register and the pins are shared by both pads
`default_nettype none

package link_pkg;

	// ----------------------------------------------------------------------
	// Poll sequencer states
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		LINK_IDLE     = 3'd0,	// Waiting for a frame request
		LINK_LATCH_HI = 3'd1,	// Latch pulse to both pads
		LINK_LATCH_LO = 3'd2,	// Latch released
		LINK_CLOCK_LO = 3'd3,	// Pad clock low, data sampled at the end
		LINK_CLOCK_HI = 3'd4,	// Pad clock high, pads shift
		LINK_DONE     = 3'd5	// Words complete
	} link_state_e;

	// ----------------------------------------------------------------------
	// Pins driven to the pads
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic latch;	// High loads the pad registers
		logic pad_clk;	// Idles high and rising edge shifts the pads
	} link_pins_t;

endpackage

`default_nettype wire

// File: hw/pad_link_reader.sv
// Pad data enters the shift registers unsynchronized and a frame during a poll is dropped
`default_nettype none

module pad_link_reader
	import link_pkg::*;
	import pad_pkg::*;
#(
	parameter int CLK_DIV_BITS = 4	// Sequencer steps once per 2**CLK_DIV_BITS cycles
)(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       frame,		// Poll request pulse
	input  logic       pad_data0,	// Active-low serial data of pad 0
	input  logic       pad_data1,	// Active-low serial data of pad 1
	output link_pins_t pins,		// Latch and clock to both pads
	output pad_word_u  word0,		// Raw wire bits of pad 0
	output pad_word_u  word1,		// Raw wire bits of pad 1
	output logic       busy,		// Request pending or poll running
	output logic       done			// One-cycle strobe, words valid
);

	// ----------------------------------------------------------------------
	// Declarations
	// ----------------------------------------------------------------------
	logic [CLK_DIV_BITS-1:0] div_cnt;	// Free-running divider
	logic                    step;		// Sequencer enable tick
	logic                    pending;	// Remembered frame request
	link_state_e             state;
	link_state_e             state_nxt;
	logic [2:0]              bit_cnt;	// Clock pairs given so far

	// ----------------------------------------------------------------------
	// Clock-enable divider
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;	// Wraps freely
	end

	assign step = &div_cnt;	// One tick per divider period

	// ----------------------------------------------------------------------
	// Request capture
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			pending <= 1'b0;
		else if (state != LINK_IDLE)
			pending <= 1'b0;	// Poll under way so requests are dropped
		else if (frame)
			pending <= 1'b1;	// Catches a single-cycle pulse
	end

	// Busy from the pending bit and the state, not from the request input
	assign busy = pending || (state != LINK_IDLE);

	// ----------------------------------------------------------------------
	// Sequencer
	// ----------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			LINK_IDLE:
			begin
				if (pending)
					state_nxt = LINK_LATCH_HI;	// Start a poll
			end
			LINK_LATCH_HI: state_nxt = LINK_LATCH_LO;
			LINK_LATCH_LO: state_nxt = LINK_CLOCK_LO;
			LINK_CLOCK_LO: state_nxt = LINK_CLOCK_HI;
			LINK_CLOCK_HI:
			begin
				if (bit_cnt == 3'd7)
					state_nxt = LINK_DONE;		// Eighth pair finished
				else
					state_nxt = LINK_CLOCK_LO;	// Next bit
			end
			default: state_nxt = LINK_IDLE;		// LINK_DONE and unused codes
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state   <= LINK_IDLE;
			bit_cnt <= 3'd0;
		end
		else if (step)
		begin
			state <= state_nxt;
			if (state == LINK_CLOCK_HI)
				bit_cnt <= bit_cnt + 3'd1;	// Wraps to 0 after the eighth pair
		end
	end

	// Leaving LINK_DONE on a tick
	assign done = step && (state == LINK_DONE);

	// ----------------------------------------------------------------------
	// Shift registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			word0 <= '0;
			word1 <= '0;
		end
		else if (step && (state == LINK_CLOCK_LO))
		begin
			word0.raw <= {word0.raw[6:0], pad_data0};	// In at the LSB
			word1.raw <= {word1.raw[6:0], pad_data1};	// So A ends in the MSB
		end
	end

	// ----------------------------------------------------------------------
	// Pad pins
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			pins.latch   <= 1'b0;
			pins.pad_clk <= 1'b1;	// Clock idles high
		end
		else
		begin
			pins.latch   <= (state == LINK_LATCH_HI);
			pins.pad_clk <= (state != LINK_CLOCK_LO);	// Low only in the low phase
		end
	end

endmodule

`default_nettype wire

// File: hw/pad_button_tracker.sv
// One tracker per pad; the first poll after reset compares against an all-released state
`default_nettype none

module pad_button_tracker
	import pad_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        done,			// Word valid strobe from the reader
	input  pad_word_u   word,			// Active-low wire bits
	output pad_report_t report,			// Held, pressed and released buttons
	output logic        report_valid	// One cycle after done
);

	// ----------------------------------------------------------------------
	// Declarations
	// ----------------------------------------------------------------------
	pad_word_u    level;		// Active-high copy of the word
	pad_buttons_t now_held;		// Buttons down in this poll
	pad_buttons_t prev_held;	// Buttons down in the poll before
	pad_report_t  report_nxt;

	// ----------------------------------------------------------------------
	// Decode
	// ----------------------------------------------------------------------
	always_comb
	begin
		level.raw = ~word.raw;	// Wire low means pressed
		now_held  = level.buttons;	// Read back by name
	end

	// Last poll's held buttons are the tracker's memory
	assign prev_held = report.held;

	// ----------------------------------------------------------------------
	// Edge detection
	// ----------------------------------------------------------------------
	always_comb
	begin
		report_nxt.held     = now_held;
		report_nxt.pressed  = pad_buttons_t'(now_held & ~prev_held);	// Newly down
		report_nxt.released = pad_buttons_t'(prev_held & ~now_held);	// Newly up
	end

	// ----------------------------------------------------------------------
	// Report register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			report <= '0;
		else if (done)
			report <= report_nxt;	// Overwritten each poll
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			report_valid <= 1'b0;
		else
			report_valid <= done;	// Same cycle as the new report
	end

endmodule

`default_nettype wire

// File: hw/pad_subsystem_top.sv
// Pad 0 and pad 1 share the latch and clock pins and the data lines are not swapped
`default_nettype none

module pad_subsystem_top
	import link_pkg::*;
	import pad_pkg::*;
#(
	parameter int CLK_DIV_BITS = 4	// One sequencer step every 16 cycles
)(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        frame,			// Poll request, e.g. vertical sync
	input  logic        pad_data0,		// Active-low data from pad 0
	input  logic        pad_data1,		// Active-low data from pad 1
	output link_pins_t  pins,			// Shared latch and pad clock
	output logic        busy,			// Poll pending or running
	output pad_report_t report0,		// Pad 0 buttons
	output pad_report_t report1,		// Pad 1 buttons
	output logic        report_valid	// Both reports updated
);

	// ----------------------------------------------------------------------
	// Reader to tracker wires
	// ----------------------------------------------------------------------
	pad_word_u word0;
	pad_word_u word1;
	logic      done;

	pad_link_reader #(
		.CLK_DIV_BITS (CLK_DIV_BITS)
	) reader (
		.clk       (clk),
		.reset_n   (reset_n),
		.frame     (frame),
		.pad_data0 (pad_data0),
		.pad_data1 (pad_data1),
		.pins      (pins),
		.word0     (word0),
		.word1     (word1),
		.busy      (busy),
		.done      (done)
	);

	// ----------------------------------------------------------------------
	// Button trackers
	// ----------------------------------------------------------------------
	pad_button_tracker track0 (
		.clk          (clk),
		.reset_n      (reset_n),
		.done         (done),
		.word         (word0),
		.report       (report0),
		.report_valid (report_valid)	// Strobe for both pads
	);

	pad_button_tracker track1 (
		.clk          (clk),
		.reset_n      (reset_n),
		.done         (done),
		.word         (word1),
		.report       (report1),
		.report_valid ()				// Same timing as track0
	);

endmodule

`default_nettype wire

// File: dv/pad_model.sv
// Ideal pads with no propagation delay; the buttons must be steady while latch is high
`default_nettype none

module pad_model
	import link_pkg::*;
	import pad_pkg::*;
(
	input  link_pins_t   pins,		// Shared latch and clock from the DUT
	input  pad_buttons_t buttons0,	// Active-high buttons of pad 0
	input  pad_buttons_t buttons1,	// Active-high buttons of pad 1
	output logic         data0,		// Active-low serial data of pad 0
	output logic         data1		// Active-low serial data of pad 1
);

	timeunit 1ns;
	timeprecision 1ps;

	logic       latch;
	logic       pad_clk;
	logic [7:0] shreg0 = '0;	// Button A sits in bit 7 after a load
	logic [7:0] shreg1 = '0;

	assign latch   = pins.latch;
	assign pad_clk = pins.pad_clk;

	// Parallel load while latch is high, shift on the rising pad clock
	always @(posedge pad_clk or posedge latch)
	begin
		if (latch)
		begin
			shreg0 <= buttons0;
			shreg1 <= buttons1;
		end
		else
		begin
			shreg0 <= {shreg0[6:0], 1'b0};	// Released buttons fill in behind
			shreg1 <= {shreg1[6:0], 1'b0};
		end
	end

	assign data0 = ~shreg0[7];	// Pressed drives the wire low
	assign data1 = ~shreg1[7];

endmodule

`default_nettype wire

// File: dv/pad_checker.sv
// Expected reports are consumed in order, one pair per report_valid strobe
`default_nettype none

module pad_checker
	import link_pkg::*;
	import pad_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        report_valid,	// Report strobe of the DUT
	input  logic        done,			// Internal strobe of the reader
	input  link_pins_t  pins,
	input  pad_report_t report0,
	input  pad_report_t report1
);

	timeunit 1ns;
	timeprecision 1ps;

	pad_report_t exp0_q[$];	// Expected pad 0 reports
	pad_report_t exp1_q[$];	// Expected pad 1 reports
	string       name_q[$];	// Poll names for the error lines
	int          errors     = 0;
	int          checks     = 0;
	int          passed     = 0;
	int          failed     = 0;
	int          test_start = 0;	// Error count when the test began
	string       test_name  = "";
	logic        done_q       = 1'b0;
	logic        latch_q      = 1'b0;
	int          latch_pulses = 0;	// Rising latch edges in this poll

	task automatic expect_reports(input string name, input pad_report_t e0, input pad_report_t e1);
		name_q.push_back(name);
		exp0_q.push_back(e0);
		exp1_q.push_back(e1);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic begin_test(input string name);
		test_name  = name;
		test_start = errors;
	endtask

	task automatic end_test();
		if (errors == test_start)
		begin
			passed++;
			$display("test %s passed", test_name);
		end
		else
		begin
			failed++;
			$display("test %s failed with %0d errors", test_name, errors - test_start);
		end
	endtask

	task automatic summary();
		$display("tests passed %0d, failed %0d, reports checked %0d, errors %0d",
			passed, failed, checks, errors);
	endtask

	// ----------------------------------------------------------------------
	// Compare on the falling edge, where registered outputs are settled
	// ----------------------------------------------------------------------
	always @(negedge clk)
	begin : compare
		string       name;
		pad_report_t e0;
		pad_report_t e1;
		if (!reset_n)
		begin
			done_q       = 1'b0;
			latch_q      = 1'b0;
			latch_pulses = 0;
		end
		else
		begin
			if (pins.latch && !latch_q)
				latch_pulses++;	// New latch pulse
			latch_q = pins.latch;
			if (report_valid != done_q)
				note_failure("report_valid did not follow done by exactly one cycle");
			done_q = done;
			if (report_valid)
			begin
				if (latch_pulses != 1)
					note_failure($sformatf("saw %0d latch pulses in one poll instead of one",
						latch_pulses));
				latch_pulses = 0;
				if (name_q.size() == 0)
					note_failure("report_valid came with no report expected");
				else
				begin
					name = name_q.pop_front();
					e0   = exp0_q.pop_front();
					e1   = exp1_q.pop_front();
					checks++;
					if (report0 !== e0)
						note_failure($sformatf("ERROR %s pad0: expected %h, actual %h",
							name, e0, report0));
					if (report1 !== e1)
						note_failure($sformatf("ERROR %s pad1: expected %h, actual %h",
							name, e1, report1));
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/pad_asserts.sv
// Attached to every pad_link_reader instance; only active outside reset
`default_nettype none

module pad_asserts
	import link_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  link_pins_t pins,
	input  logic       busy,
	input  logic       done
);

	timeunit 1ns;
	timeprecision 1ps;

	// Pads must never see a clock edge during the load
	latch_clk_apart: assert property (@(posedge clk) disable iff (!reset_n)
		!(pins.latch && !pins.pad_clk))
		else $error("latch high while pad clock is low");

	done_in_poll: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> busy)
		else $error("done strobe outside a poll");

	// Idle pins whenever nothing is pending or running
	idle_pins: assert property (@(posedge clk) disable iff (!reset_n)
		!busy |-> (!pins.latch && pins.pad_clk))
		else $error("pad pins active while not busy");

endmodule

bind pad_link_reader pad_asserts asrt0 (
	.clk     (clk),
	.reset_n (reset_n),
	.pins    (pins),
	.busy    (busy),
	.done    (done)
);

`default_nettype wire

// File: dv/pad_tb.sv
// Each poll waits for its report before the next frame; the divider is left at its default width
`default_nettype none

module pad_tb
	import link_pkg::*;
	import pad_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int POLL_CYCLES = 340;	// 20 steps of 16 cycles plus divider phase
	localparam int MAX_POLLS   = 30;
	localparam int MAX_CYCLES  = MAX_POLLS * POLL_CYCLES + 1800;
	localparam int WAIT_LIMIT  = 400;	// Per-poll wait for report_valid

	logic         clk;
	logic         reset_n;
	logic         frame;
	logic         pad_data0;
	logic         pad_data1;
	link_pins_t   pins;
	logic         busy;
	logic         report_valid;
	pad_report_t  report0;
	pad_report_t  report1;
	pad_buttons_t btn0;			// Buttons held on pad 0
	pad_buttons_t btn1;
	pad_buttons_t prev0;		// Held buttons of the previous poll
	pad_buttons_t prev1;
	int           cycles = 0;

	pad_subsystem_top #(.CLK_DIV_BITS(4)) dut0 (
		.clk (clk), .reset_n (reset_n), .frame (frame),
		.pad_data0 (pad_data0), .pad_data1 (pad_data1), .pins (pins), .busy (busy),
		.report0 (report0), .report1 (report1), .report_valid (report_valid)
	);

	pad_model pads (
		.pins (pins), .buttons0 (btn0), .buttons1 (btn1), .data0 (pad_data0), .data1 (pad_data1)
	);

	pad_checker chk (
		.clk (clk), .reset_n (reset_n), .report_valid (report_valid),
		.done (dut0.reader.done), .pins (pins), .report0 (report0), .report1 (report1)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// Held, pressed and released from the previous and the new buttons
	function automatic pad_report_t expected_report(input pad_buttons_t prev,
		input pad_buttons_t now);
		pad_report_t r;
		r.held     = now;
		r.pressed  = pad_buttons_t'(now & ~prev);
		r.released = pad_buttons_t'(prev & ~now);
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// Poll helpers
	// ----------------------------------------------------------------------
	task automatic start_poll(input string name, input pad_buttons_t b0, input pad_buttons_t b1);
		chk.expect_reports(name, expected_report(prev0, b0), expected_report(prev1, b1));
		prev0 = b0;
		prev1 = b1;
		@(negedge clk);
		btn0  = b0;
		btn1  = b1;
		frame = 1'b1;	// Single-cycle request
		@(negedge clk);
		frame = 1'b0;
	endtask

	task automatic wait_report(input string name);
		int n;
		n = 0;
		while (!report_valid && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!report_valid)
			chk.note_failure($sformatf("%s: no report_valid within %0d cycles",
				name, WAIT_LIMIT));
		repeat (3) @(negedge clk);	// Let the checker consume it
	endtask

	task automatic run_poll(input string name, input pad_buttons_t b0, input pad_buttons_t b1);
		start_poll(name, b0, b1);
		wait_report(name);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial
	begin
		pad_buttons_t a_only;
		pad_buttons_t right_only;
		logic [31:0]  rnd;
		int           bad;
		rnd        = $urandom(42);	// Seed once
		a_only     = '0;
		a_only.a   = 1'b1;
		right_only = '0;
		right_only.right = 1'b1;
		reset_n = 1'b0;
		frame   = 1'b0;
		btn0    = '0;
		btn1    = '0;
		prev0   = '0;
		prev1   = '0;
		bad     = 0;
		repeat (8) @(negedge clk);
		reset_n = 1'b1;

		chk.begin_test("reset_quiet");
		repeat (100)
		begin
			@(negedge clk);
			if (pins.latch || !pins.pad_clk || busy || report_valid)
				bad++;
		end
		if (bad != 0)
			chk.note_failure("pins, busy or report_valid active with no frame given");
		chk.end_test();

		chk.begin_test("single_poll");
		run_poll("single_a_right", a_only, right_only);
		run_poll("single_mixed", pad_buttons_t'(8'h5A), pad_buttons_t'(8'hC3));
		run_poll("single_swap", right_only, a_only);
		chk.end_test();

		chk.begin_test("edges");
		run_poll("edges_first", pad_buttons_t'(8'b1100_1010), pad_buttons_t'(8'b0011_0110));
		run_poll("edges_second", pad_buttons_t'(8'b1010_1100), pad_buttons_t'(8'b0110_0011));
		chk.end_test();

		chk.begin_test("random");
		for (int i = 0; i < 20; i++)
		begin
			rnd = $urandom();
			run_poll($sformatf("random_%0d", i), rnd[7:0], rnd[15:8]);
		end
		chk.end_test();

		chk.begin_test("frame_while_busy");
		start_poll("busy_poll", pad_buttons_t'(8'h81), pad_buttons_t'(8'h18));
		repeat (60) @(negedge clk);
		if (!busy)
			chk.note_failure("busy was low in the middle of a poll");
		frame = 1'b1;	// Must be dropped
		@(negedge clk);
		frame = 1'b0;
		wait_report("busy_poll");
		bad = 0;
		repeat (60)
		begin
			@(negedge clk);
			if (busy || report_valid)
				bad++;
		end
		if (bad != 0)
			chk.note_failure("a frame given during a poll started a second poll");
		chk.end_test();

		chk.begin_test("strobe_timing");
		run_poll("strobe_first", pad_buttons_t'(8'hFF), pad_buttons_t'(8'h00));
		run_poll("strobe_second", pad_buttons_t'(8'h00), pad_buttons_t'(8'hFF));
		chk.end_test();

		chk.summary();
		if (chk.errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hw/pad_pkg.sv
hw/link_pkg.sv
hw/pad_link_reader.sv
hw/pad_button_tracker.sv
hw/pad_subsystem_top.sv
dv/pad_model.sv
dv/pad_checker.sv
dv/pad_asserts.sv
dv/pad_tb.sv

// File: Makefile
# Verilator build and run of the pad subsystem testbench

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module pad_tb -Mdir obj_dir

run: build
	./obj_dir/Vpad_tb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module pad_tb
	verilator --lint-only -Wall hw/pad_pkg.sv hw/link_pkg.sv hw/pad_link_reader.sv \
		hw/pad_button_tracker.sv hw/pad_subsystem_top.sv --top-module pad_subsystem_top

clean:
	rm -rf obj_dir $(LOG)
